/* project.f */
+incdir+design
design/soc_pkg.sv
design/wb_if.sv
design/bus_arbiter.sv
design/addr_decoder.sv
design/clint_timer.sv
design/ram_bridge.sv
design/soc_top.sv
dv/tb_soc_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the fabric testbench with Verilator, run it, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f project.f \
    --top-module tb_soc_top -o tb_soc_top \
    && ./obj_dir/tb_soc_top | tee sim.log \
    && grep -q "^Test OK$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* dv/tb_soc_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the memory fabric top,
// with an external RAM model and a cycle watchdog
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module tb_soc_top;
    import soc_pkg::*;

    // six tests take about 300 cycles
    localparam int    MAX_CYCLES  = 2000;
    localparam int    ACK_WAIT    = 20;
    localparam data_t RAM_PATTERN = 64'h5a3c_96f0_0ff0_c3a5;

    logic  clk = 1'b0;
    logic  i_rst;
    logic  i_if_req;
    addr_t i_if_addr;
    data_t o_if_data;
    logic  o_if_ack;
    logic  i_d_req;
    logic  i_d_we;
    addr_t i_d_addr;
    data_t i_d_wdata;
    strb_t i_d_strb;
    data_t o_d_rdata;
    logic  o_d_ack;
    logic  o_ram_rd_en;
    addr_t o_ram_addr;
    data_t i_ram_rd_data;
    logic  o_ram_wr_en;
    addr_t o_ram_wr_addr;
    data_t o_ram_wr_data;
    strb_t o_ram_wr_strb;
    logic  o_timer_irq;

    integer seed = 70865;
    int     err_cnt = 0;
    int     test_cnt = 0;
    int     test_fail = 0;
    int     cycle_cnt = 0;
    int     ram_en_cnt = 0;
    logic   irq_at_reset;
    addr_t  wr_addr_q[$];
    data_t  wr_data_q[$];
    strb_t  wr_strb_q[$];

    soc_top dut0 (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_if_req      (i_if_req),
        .i_if_addr     (i_if_addr),
        .o_if_data     (o_if_data),
        .o_if_ack      (o_if_ack),
        .i_d_req       (i_d_req),
        .i_d_we        (i_d_we),
        .i_d_addr      (i_d_addr),
        .i_d_wdata     (i_d_wdata),
        .i_d_strb      (i_d_strb),
        .o_d_rdata     (o_d_rdata),
        .o_d_ack       (o_d_ack),
        .o_ram_rd_en   (o_ram_rd_en),
        .o_ram_addr    (o_ram_addr),
        .i_ram_rd_data (i_ram_rd_data),
        .o_ram_wr_en   (o_ram_wr_en),
        .o_ram_wr_addr (o_ram_wr_addr),
        .o_ram_wr_data (o_ram_wr_data),
        .o_ram_wr_strb (o_ram_wr_strb),
        .o_timer_irq   (o_timer_irq)
    );

    always #2 clk = ~clk;

    // RAM content is the address XOR a fixed pattern
    function automatic data_t ram_word(input addr_t a);
        return a ^ RAM_PATTERN;
    endfunction

    assign i_ram_rd_data = o_ram_rd_en ? ram_word(o_ram_addr) : '0;

    // write log and enable count taken mid cycle
    always @(negedge clk) begin
        if (!i_rst && o_ram_wr_en) begin
            wr_addr_q.push_back(o_ram_wr_addr);
            wr_data_q.push_back(o_ram_wr_data);
            wr_strb_q.push_back(o_ram_wr_strb);
        end
        if (!i_rst && (o_ram_rd_en || o_ram_wr_en)) begin
            ram_en_cnt++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // word aligned and never one of the timer words
    function automatic addr_t rand_ram_addr();
        addr_t a;
        a = {$random(seed), $random(seed)};
        a[2:0] = 3'b000;
        if (a == `SOC_MTIME_ADDR || a == `SOC_MTIMECMP_ADDR) begin
            a = a + 64'h8;
        end
        return a;
    endfunction

    function automatic data_t rand_data();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic report_mismatch(input string name, input data_t exp, input data_t act);
        $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        err_cnt++;
    endtask

    task automatic report_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic end_test(input string name, input int e0);
        test_cnt++;
        if (err_cnt == e0) begin
            $display("%s: passed", name);
        end else begin
            test_fail++;
            $display("%s: failed with %0d errors", name, err_cnt - e0);
        end
    endtask

    // one fetch read where lat counts cycles from request to ack
    task automatic fetch_read(input addr_t addr, output data_t rdata, output int lat);
        int waited;
        bit done;
        waited = 0;
        done = 1'b0;
        rdata = '0;
        @(posedge clk);
        i_if_req  <= 1'b1;
        i_if_addr <= addr;
        while (!done && waited < ACK_WAIT) begin
            @(negedge clk);
            if (o_d_ack) begin
                report_error("data ack raised during a fetch");
            end
            if (o_if_ack) begin
                rdata = o_if_data;
                done = 1'b1;
            end else begin
                waited++;
            end
        end
        lat = waited;
        if (!done) begin
            report_error("fetch request got no ack");
        end
        @(posedge clk);
        i_if_req <= 1'b0;
    endtask

    task automatic data_xfer(input logic we, input addr_t addr, input data_t wdata,
                             input strb_t strb, output data_t rdata, output int lat);
        int waited;
        bit done;
        waited = 0;
        done = 1'b0;
        rdata = '0;
        @(posedge clk);
        i_d_req   <= 1'b1;
        i_d_we    <= we;
        i_d_addr  <= addr;
        i_d_wdata <= wdata;
        i_d_strb  <= strb;
        while (!done && waited < ACK_WAIT) begin
            @(negedge clk);
            if (o_if_ack) begin
                report_error("fetch ack raised during a data transfer");
            end
            if (o_d_ack) begin
                rdata = o_d_rdata;
                done = 1'b1;
            end else begin
                waited++;
            end
        end
        lat = waited;
        if (!done) begin
            report_error("data request got no ack");
        end
        @(posedge clk);
        i_d_req <= 1'b0;
    endtask

    task automatic test_fetch_read();
        int    e0;
        int    lat;
        addr_t a;
        data_t rd;
        e0 = err_cnt;
        for (int i = 0; i < 4; i++) begin
            a = rand_ram_addr();
            fetch_read(a, rd, lat);
            if (rd !== ram_word(a)) begin
                report_mismatch("o_if_data", ram_word(a), rd);
            end
        end
        end_test("fetch read", e0);
    endtask

    task automatic test_data_write_read();
        int          e0;
        int          lat;
        int          n0;
        logic [31:0] r32;
        addr_t       a;
        addr_t       b;
        data_t       w;
        data_t       rd;
        strb_t       s;
        e0 = err_cnt;
        a = rand_ram_addr();
        w = rand_data();
        r32 = $random(seed);
        s = r32[7:0];
        if (s == '0) begin
            s = 8'h0f;
        end
        n0 = wr_addr_q.size();
        data_xfer(1'b1, a, w, s, rd, lat);
        if (wr_addr_q.size() != n0 + 1) begin
            report_error("RAM model did not see exactly one write");
        end else begin
            if (wr_addr_q[n0] !== a) begin
                report_mismatch("o_ram_wr_addr", a, wr_addr_q[n0]);
            end
            if (wr_data_q[n0] !== w) begin
                report_mismatch("o_ram_wr_data", w, wr_data_q[n0]);
            end
            if (wr_strb_q[n0] !== s) begin
                report_mismatch("o_ram_wr_strb", 64'(s), 64'(wr_strb_q[n0]));
            end
        end
        b = rand_ram_addr();
        if (b == a) begin
            b = b + 64'h8;
        end
        data_xfer(1'b0, b, '0, 8'hff, rd, lat);
        if (rd !== ram_word(b)) begin
            report_mismatch("o_d_rdata", ram_word(b), rd);
        end
        end_test("data write and read", e0);
    endtask

    // both sides stay pending so acks alternate data then fetch
    task automatic test_arbitration();
        int    e0;
        int    lat;
        int    d_cnt;
        int    f_cnt;
        int    n;
        int    waited;
        bit    got_d;
        bit    got_f;
        data_t rd;
        e0 = err_cnt;
        // leave fetch as the last served side
        fetch_read(rand_ram_addr(), rd, lat);
        d_cnt = 0;
        f_cnt = 0;
        n = 0;
        waited = 0;
        @(posedge clk);
        i_if_req  <= 1'b1;
        i_if_addr <= rand_ram_addr();
        i_d_req   <= 1'b1;
        i_d_we    <= 1'b0;
        i_d_addr  <= rand_ram_addr();
        i_d_strb  <= 8'hff;
        while ((d_cnt < 3 || f_cnt < 3) && waited < 6 * ACK_WAIT) begin
            @(negedge clk);
            waited++;
            got_d = o_d_ack;
            got_f = o_if_ack;
            if (got_d && got_f) begin
                report_error("both requesters acked in the same cycle");
            end
            if (got_d) begin
                if (o_d_rdata !== ram_word(i_d_addr)) begin
                    report_mismatch("o_d_rdata", ram_word(i_d_addr), o_d_rdata);
                end
                if (n % 2 != 0) begin
                    report_error("data acked out of turn");
                end
                d_cnt++;
                n++;
            end
            if (got_f) begin
                if (o_if_data !== ram_word(i_if_addr)) begin
                    report_mismatch("o_if_data", ram_word(i_if_addr), o_if_data);
                end
                if (n % 2 != 1) begin
                    report_error("fetch acked out of turn");
                end
                f_cnt++;
                n++;
            end
            @(posedge clk);
            if (got_d) begin
                if (d_cnt == 3) begin
                    i_d_req <= 1'b0;
                end else begin
                    i_d_addr <= rand_ram_addr();
                end
            end
            if (got_f) begin
                if (f_cnt == 3) begin
                    i_if_req <= 1'b0;
                end else begin
                    i_if_addr <= rand_ram_addr();
                end
            end
        end
        if (d_cnt < 3 || f_cnt < 3) begin
            report_error("contending requests stalled");
            i_d_req  <= 1'b0;
            i_if_req <= 1'b0;
        end
        end_test("arbitration", e0);
    endtask

    task automatic test_timer_regs();
        int          e0;
        int          lat;
        int          en0;
        logic [31:0] r32;
        data_t       v;
        data_t       rd;
        data_t       t1;
        data_t       t2;
        data_t       old;
        data_t       w;
        data_t       exp;
        strb_t       s;
        e0 = err_cnt;
        en0 = ram_en_cnt;
        r32 = $random(seed);
        v = {32'h0000_1000, r32};
        data_xfer(1'b1, `SOC_MTIME_ADDR, v, 8'hff, rd, lat);
        data_xfer(1'b0, `SOC_MTIME_ADDR, '0, 8'hff, rd, lat);
        if (rd < v || rd > v + 64'd20) begin
            report_mismatch("mtime", v, rd);
        end
        data_xfer(1'b0, `SOC_MTIME_ADDR, '0, 8'hff, t1, lat);
        data_xfer(1'b0, `SOC_MTIME_ADDR, '0, 8'hff, t2, lat);
        if (t2 <= t1) begin
            report_error("second mtime read is not larger than the first");
        end
        data_xfer(1'b0, `SOC_MTIMECMP_ADDR, '0, 8'hff, old, lat);
        w = rand_data();
        s = 8'b0010_0101;
        data_xfer(1'b1, `SOC_MTIMECMP_ADDR, w, s, rd, lat);
        data_xfer(1'b0, `SOC_MTIMECMP_ADDR, '0, 8'hff, rd, lat);
        // selected bytes take the new value, the others keep the old one
        exp = old;
        for (int i = 0; i < `SOC_STRB_W; i++) begin
            if (s[i]) begin
                exp[8*i +: 8] = w[8*i +: 8];
            end
        end
        if (rd !== exp) begin
            report_mismatch("mtimecmp", exp, rd);
        end
        // compare back out of reach
        data_xfer(1'b1, `SOC_MTIMECMP_ADDR, `SOC_MTIMECMP_RST, 8'hff, rd, lat);
        if (ram_en_cnt != en0) begin
            report_error("a timer access raised a RAM enable");
        end
        end_test("timer registers", e0);
    endtask

    task automatic test_interrupt();
        int    e0;
        int    lat;
        int    waited;
        bit    seen;
        data_t t;
        data_t rd;
        e0 = err_cnt;
        if (irq_at_reset !== 1'b0) begin
            report_error("timer interrupt high after reset");
        end
        data_xfer(1'b0, `SOC_MTIME_ADDR, '0, 8'hff, t, lat);
        data_xfer(1'b1, `SOC_MTIMECMP_ADDR, t + 64'd30, 8'hff, rd, lat);
        waited = 0;
        seen = 1'b0;
        while (!seen && waited < 60) begin
            @(negedge clk);
            if (o_timer_irq) begin
                seen = 1'b1;
            end else begin
                waited++;
            end
        end
        if (!seen) begin
            report_error("timer interrupt did not rise within 60 cycles");
        end
        data_xfer(1'b1, `SOC_MTIMECMP_ADDR, `SOC_MTIMECMP_RST, 8'hff, rd, lat);
        @(negedge clk);
        if (o_timer_irq !== 1'b0) begin
            report_error("timer interrupt still high after mtimecmp set to all ones");
        end
        end_test("timer interrupt", e0);
    endtask

    task automatic test_latency();
        int    e0;
        int    lat;
        data_t rd;
        e0 = err_cnt;
        fetch_read(rand_ram_addr(), rd, lat);
        if (lat != 2) begin
            report_mismatch("fetch ack latency", 64'd2, 64'(lat));
        end
        data_xfer(1'b0, rand_ram_addr(), '0, 8'hff, rd, lat);
        if (lat != 2) begin
            report_mismatch("data read ack latency", 64'd2, 64'(lat));
        end
        data_xfer(1'b1, rand_ram_addr(), rand_data(), 8'hff, rd, lat);
        if (lat != 2) begin
            report_mismatch("data write ack latency", 64'd2, 64'(lat));
        end
        data_xfer(1'b0, `SOC_MTIME_ADDR, '0, 8'hff, rd, lat);
        if (lat != 2) begin
            report_mismatch("timer read ack latency", 64'd2, 64'(lat));
        end
        end_test("latency", e0);
    endtask

    initial begin
        i_rst     <= 1'b1;
        i_if_req  <= 1'b0;
        i_if_addr <= '0;
        i_d_req   <= 1'b0;
        i_d_we    <= 1'b0;
        i_d_addr  <= '0;
        i_d_wdata <= '0;
        i_d_strb  <= '0;
        repeat (2) @(posedge clk);
        i_rst <= 1'b0;
        @(negedge clk);
        irq_at_reset = o_timer_irq;

        test_fetch_read();
        test_data_write_read();
        test_arbitration();
        test_timer_regs();
        test_interrupt();
        test_latency();

        $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/soc_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory fabric top: requester ports in, external
// RAM strobes and timer interrupt out
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module soc_top (
    input  wire             clk,
    input  wire             i_rst,
    // instruction fetch requester
    input  wire             i_if_req,
    input  soc_pkg::addr_t  i_if_addr,
    output soc_pkg::data_t  o_if_data,
    output logic            o_if_ack,
    // data requester
    input  wire             i_d_req,
    input  wire             i_d_we,
    input  soc_pkg::addr_t  i_d_addr,
    input  soc_pkg::data_t  i_d_wdata,
    input  soc_pkg::strb_t  i_d_strb,
    output soc_pkg::data_t  o_d_rdata,
    output logic            o_d_ack,
    // external RAM
    output logic            o_ram_rd_en,
    output soc_pkg::addr_t  o_ram_addr,
    input  soc_pkg::data_t  i_ram_rd_data,
    output logic            o_ram_wr_en,
    output soc_pkg::addr_t  o_ram_wr_addr,
    output soc_pkg::data_t  o_ram_wr_data,
    output soc_pkg::strb_t  o_ram_wr_strb,
    output logic            o_timer_irq
);

    wb_if wb_arb ();
    wb_if wb_tmr ();
    wb_if wb_ram ();

    bus_arbiter u_arb (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_if_req  (i_if_req),
        .i_if_addr (i_if_addr),
        .o_if_data (o_if_data),
        .o_if_ack  (o_if_ack),
        .i_d_req   (i_d_req),
        .i_d_we    (i_d_we),
        .i_d_addr  (i_d_addr),
        .i_d_wdata (i_d_wdata),
        .i_d_strb  (i_d_strb),
        .o_d_rdata (o_d_rdata),
        .o_d_ack   (o_d_ack),
        .m_bus     (wb_arb)
    );

    addr_decoder u_dec (
        .s_bus (wb_arb),
        .m_tmr (wb_tmr),
        .m_ram (wb_ram)
    );

    clint_timer u_tmr (
        .clk         (clk),
        .i_rst       (i_rst),
        .s_bus       (wb_tmr),
        .o_timer_irq (o_timer_irq)
    );

    ram_bridge u_ram (
        .clk           (clk),
        .i_rst         (i_rst),
        .s_bus         (wb_ram),
        .o_ram_rd_en   (o_ram_rd_en),
        .o_ram_addr    (o_ram_addr),
        .i_ram_rd_data (i_ram_rd_data),
        .o_ram_wr_en   (o_ram_wr_en),
        .o_ram_wr_addr (o_ram_wr_addr),
        .o_ram_wr_data (o_ram_wr_data),
        .o_ram_wr_strb (o_ram_wr_strb)
    );

endmodule

`default_nettype wire

/* design/ram_bridge.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone slave driving the external RAM strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module ram_bridge (
    input  wire             clk,
    input  wire             i_rst,
    wb_if.slave             s_bus,
    // read port
    output logic            o_ram_rd_en,
    output soc_pkg::addr_t  o_ram_addr,
    input  soc_pkg::data_t  i_ram_rd_data,
    // write port
    output logic            o_ram_wr_en,
    output soc_pkg::addr_t  o_ram_wr_addr,
    output soc_pkg::data_t  o_ram_wr_data,
    output soc_pkg::strb_t  o_ram_wr_strb
);
    import soc_pkg::*;

    data_t rdata_q;
    logic  ack_q;
    logic  req;

    assign req = s_bus.cyc & s_bus.stb & ~ack_q;

    // one access per transfer in the cycle before ack
    assign o_ram_rd_en   = req & ~s_bus.we;
    assign o_ram_wr_en   = req & s_bus.we;
    assign o_ram_addr    = s_bus.adr;
    assign o_ram_wr_addr = s_bus.adr;
    assign o_ram_wr_data = s_bus.dat_w;
    assign o_ram_wr_strb = s_bus.sel;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (o_ram_rd_en) begin
            rdata_q <= i_ram_rd_data;
        end
    end

    assign s_bus.ack   = ack_q;
    assign s_bus.dat_r = rdata_q;

    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (i_rst)
        !(o_ram_rd_en && o_ram_wr_en)
    );

endmodule

`default_nettype wire

/* design/clint_timer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// machine timer: mtime, mtimecmp and the timer
// interrupt, reached as a Wishbone slave
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module clint_timer (
    input  wire  clk,
    input  wire  i_rst,
    wb_if.slave  s_bus,
    output logic o_timer_irq
);
    import soc_pkg::*;

    data_t mtime;
    data_t mtimecmp;
    data_t wr_mask;
    data_t rdata_q;
    logic  ack_q;
    logic  req;
    logic  hit_time;
    logic  hit_cmp;

    assign hit_time = (s_bus.adr == `SOC_MTIME_ADDR);
    assign hit_cmp  = (s_bus.adr == `SOC_MTIMECMP_ADDR);

    // new request only while no ack is out
    assign req = s_bus.cyc & s_bus.stb & ~ack_q;

    // byte strobes widened to a bit mask
    always_comb begin
        for (int i = 0; i < `SOC_STRB_W; i++) begin
            wr_mask[8*i +: 8] = {8{s_bus.sel[i]}};
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            mtime <= '0;
        end else if (req && s_bus.we && hit_time) begin
            mtime <= (mtime & ~wr_mask) | (s_bus.dat_w & wr_mask);
        end else begin
            mtime <= mtime + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            mtimecmp <= `SOC_MTIMECMP_RST;
        end else if (req && s_bus.we && hit_cmp) begin
            mtimecmp <= (mtimecmp & ~wr_mask) | (s_bus.dat_w & wr_mask);
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    // read word sampled in the request cycle
    always_ff @(posedge clk) begin
        if (req) begin
            rdata_q <= hit_cmp ? mtimecmp : mtime;
        end
    end

    assign s_bus.ack   = ack_q;
    assign s_bus.dat_r = rdata_q;

    // level interrupt, cleared by moving mtimecmp ahead
    assign o_timer_irq = (mtime >= mtimecmp);

    // master must still hold the cycle when the ack lands
    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (i_rst)
        ack_q |-> (s_bus.cyc && s_bus.stb)
    );

endmodule

`default_nettype wire

/* design/addr_decoder.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// steers a Wishbone transfer to the timer or
// to the RAM bridge by its address
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module addr_decoder (
    wb_if.slave  s_bus,
    wb_if.master m_tmr,
    wb_if.master m_ram
);
    import soc_pkg::*;

    slave_sel_e sel_slv;

    // only the two timer words go to the timer
    assign sel_slv = ((s_bus.adr == `SOC_MTIME_ADDR) || (s_bus.adr == `SOC_MTIMECMP_ADDR))
                   ? SLV_TIMER : SLV_RAM;

    // address and payload are shared by both slaves
    assign m_tmr.adr   = s_bus.adr;
    assign m_tmr.dat_w = s_bus.dat_w;
    assign m_tmr.sel   = s_bus.sel;
    assign m_tmr.we    = s_bus.we;
    assign m_ram.adr   = s_bus.adr;
    assign m_ram.dat_w = s_bus.dat_w;
    assign m_ram.sel   = s_bus.sel;
    assign m_ram.we    = s_bus.we;

    // cycle qualifiers reach the selected slave only
    assign m_tmr.cyc = s_bus.cyc & (sel_slv == SLV_TIMER);
    assign m_tmr.stb = s_bus.stb & (sel_slv == SLV_TIMER);
    assign m_ram.cyc = s_bus.cyc & (sel_slv == SLV_RAM);
    assign m_ram.stb = s_bus.stb & (sel_slv == SLV_RAM);

    assign s_bus.ack   = (sel_slv == SLV_TIMER) ? m_tmr.ack : m_ram.ack;
    assign s_bus.dat_r = (sel_slv == SLV_TIMER) ? m_tmr.dat_r : m_ram.dat_r;

    // both slaves answering at once means the select leaked
    always_comb begin
        a_one_ack: assert (!(m_tmr.ack && m_ram.ack));
    end

endmodule

`default_nettype wire

/* design/bus_arbiter.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// picks fetch or data requester and runs the
// chosen transfer as a Wishbone classic master
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module bus_arbiter (
    input  wire              clk,
    input  wire              i_rst,
    // instruction fetch, read only
    input  wire              i_if_req,
    input  soc_pkg::addr_t   i_if_addr,
    output soc_pkg::data_t   o_if_data,
    output logic             o_if_ack,
    // data port
    input  wire              i_d_req,
    input  wire              i_d_we,
    input  soc_pkg::addr_t   i_d_addr,
    input  soc_pkg::data_t   i_d_wdata,
    input  soc_pkg::strb_t   i_d_strb,
    output soc_pkg::data_t   o_d_rdata,
    output logic             o_d_ack,
    wb_if.master             m_bus
);

    logic gnt_if;
    logic gnt_d;
    logic last_d;
    logic idle;
    logic pick_d;
    logic pick_if;

    assign idle = ~gnt_if & ~gnt_d;

    // data first, unless data had the last turn and fetch waits
    assign pick_d  = i_d_req & (~i_if_req | ~last_d);
    assign pick_if = i_if_req & ~pick_d;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            gnt_if <= 1'b0;
            gnt_d  <= 1'b0;
            last_d <= 1'b0;
        end else if (m_bus.ack) begin
            // transfer done, release the bus on the ack edge
            gnt_if <= 1'b0;
            gnt_d  <= 1'b0;
        end else if (idle) begin
            gnt_if <= pick_if;
            gnt_d  <= pick_d;
            if (i_if_req | i_d_req) begin
                last_d <= pick_d;
            end
        end
    end

    // bus side, held stable by the requester until its ack
    assign m_bus.cyc   = gnt_if | gnt_d;
    assign m_bus.stb   = gnt_if | gnt_d;
    assign m_bus.adr   = gnt_d ? i_d_addr : i_if_addr;
    assign m_bus.we    = gnt_d & i_d_we;
    assign m_bus.dat_w = gnt_d ? i_d_wdata : '0;
    // a fetch always reads the whole word
    assign m_bus.sel   = gnt_d ? i_d_strb : {`SOC_STRB_W{1'b1}};

    // response goes only to the side holding the grant
    assign o_if_ack  = m_bus.ack & gnt_if;
    assign o_d_ack   = m_bus.ack & gnt_d;
    assign o_if_data = gnt_if ? m_bus.dat_r : '0;
    assign o_d_rdata = gnt_d ? m_bus.dat_r : '0;

    // one owner of the bus at a time
    a_one_grant: assert property (
        @(posedge clk) disable iff (i_rst)
        !(gnt_if && gnt_d)
    );

endmodule

`default_nettype wire

/* design/wb_if.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic bus between fabric blocks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

interface wb_if;
    import soc_pkg::*;

    addr_t adr;
    data_t dat_w;
    data_t dat_r;
    strb_t sel;
    logic  we;
    logic  cyc;
    logic  stb;
    // one cycle pulse from the slave
    logic  ack;

    modport master (output adr, dat_w, sel, we, cyc, stb, input dat_r, ack);

    modport slave (input adr, dat_w, sel, we, cyc, stb, output dat_r, ack);

endinterface

`default_nettype wire

/* design/soc_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus types shared by the fabric modules
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "soc_settings.svh"

package soc_pkg;

    typedef logic [`SOC_ADDR_W-1:0] addr_t;
    typedef logic [`SOC_DATA_W-1:0] data_t;

    // bit n enables byte n of the data word
    typedef logic [`SOC_STRB_W-1:0] strb_t;

    // target chosen by the address decoder
    typedef enum logic [0:0] {
        SLV_RAM   = 1'b0,
        SLV_TIMER = 1'b1
    } slave_sel_e;

endpackage

`default_nettype wire

/* design/soc_settings.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address map, bus widths and timer reset values
// for the memory fabric, included by every design file
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// bus widths
`define SOC_ADDR_W        64
`define SOC_DATA_W        64
`define SOC_STRB_W        8

// machine timer registers, everything else is RAM
`define SOC_MTIME_ADDR    64'h0000_0000_0200_bff8
`define SOC_MTIMECMP_ADDR 64'h0000_0000_0200_4000

// compare value out of reach so the interrupt stays quiet
`define SOC_MTIMECMP_RST  64'hffff_ffff_ffff_ffff

`endif
